// File: hw/dcachePkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared geometry, address view and bus structs for the data
// cache; modules refer to these by dcachePkg:: scoped names
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dcachePkg;

    localparam int ADDR_WIDTH  = 16;
    localparam int OFFSET_BITS = 4;
    localparam int SET_BITS    = 5;
    localparam int TAG_BITS    = ADDR_WIDTH - SET_BITS - OFFSET_BITS;
    localparam int NUM_SETS    = 32;
    localparam int NUM_WAYS    = 2;
    localparam int BLOCK_BYTES = 16;
    localparam int BLOCK_BITS  = BLOCK_BYTES * 8;
    localparam int WORD_BYTES  = 4;
    localparam int MEM_BLOCKS  = 4096;

    // Same 16-bit address, seen by the array or by the memory link
    typedef union packed {
        struct packed {
            logic [TAG_BITS-1:0]                         tag;
            logic [SET_BITS-1:0]                         setIdx;
            logic [$clog2(BLOCK_BYTES/WORD_BYTES)-1:0]   wordSel;
            logic [$clog2(WORD_BYTES)-1:0]               byteSel;  // ignored, aligned only
        } field;
        struct packed {
            logic [$clog2(MEM_BLOCKS)-1:0] blockNum;
            logic [OFFSET_BITS-1:0]        offset;
        } block;
    } dcacheAddr_u;

    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [ADDR_WIDTH-1:0]   paddr;
        logic [WORD_BYTES*8-1:0] pwdata;
        logic [WORD_BYTES-1:0]   pstrb;
    } apbReq_t;

    typedef struct packed {
        logic                    pready;
        logic [WORD_BYTES*8-1:0] prdata;
    } apbResp_t;

    typedef struct packed {
        logic                          valid;
        logic                          write;
        logic [$clog2(MEM_BLOCKS)-1:0] blockNum;
        logic [BLOCK_BITS-1:0]         data;
    } memReq_t;

    typedef struct packed {
        logic                  done;   // one-cycle pulse
        logic [BLOCK_BITS-1:0] data;
    } memResp_t;

    typedef struct packed {
        logic                   lookup;    // read hit completing, touch status
        logic                   writeHit;
        logic                   fill;
        dcacheAddr_u            addr;
        logic [BLOCK_BYTES-1:0] strobe;    // already at word position
        logic [BLOCK_BITS-1:0]  data;
    } arrayCmd_t;

endpackage

// File: hw/dcacheArray.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-way set-associative storage with combinational hit and
// victim lookup; writes and fills land on the next clock edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module dcacheArray (
    input  logic                                clk,
    input  logic                                rst,
    input  dcachePkg::arrayCmd_t                cmd,
    output logic                                hit,
    output logic                                victimDirty,
    output logic [dcachePkg::TAG_BITS-1:0]      victimTag,
    output logic [dcachePkg::BLOCK_BITS-1:0]    readBlock
);

    localparam int WAY_BITS = $clog2(dcachePkg::NUM_WAYS);

    // Per-set control bits, one per way
    logic [dcachePkg::NUM_WAYS-1:0] validBits  [dcachePkg::NUM_SETS];
    logic [dcachePkg::NUM_WAYS-1:0] dirtyBits  [dcachePkg::NUM_SETS];
    logic [dcachePkg::NUM_WAYS-1:0] statusBits [dcachePkg::NUM_SETS];  // pseudo-LRU

    logic [dcachePkg::TAG_BITS-1:0]   tagMem  [dcachePkg::NUM_SETS][dcachePkg::NUM_WAYS];
    logic [dcachePkg::BLOCK_BITS-1:0] dataMem [dcachePkg::NUM_SETS][dcachePkg::NUM_WAYS];

    logic [dcachePkg::SET_BITS-1:0] setIdx;
    logic [dcachePkg::TAG_BITS-1:0] reqTag;
    logic [dcachePkg::NUM_WAYS-1:0] hitWay;
    logic [WAY_BITS-1:0]            hitIdx;
    logic [WAY_BITS-1:0]            victimIdx;

    assign setIdx = cmd.addr.field.setIdx;
    assign reqTag = cmd.addr.field.tag;

    // Set accessed way; if the whole set would be marked, keep only that way
    function automatic logic [dcachePkg::NUM_WAYS-1:0] touchStatus(
        input logic [dcachePkg::NUM_WAYS-1:0] old,
        input logic [WAY_BITS-1:0]            way
    );
        logic [dcachePkg::NUM_WAYS-1:0] upd;
        upd      = old;
        upd[way] = 1'b1;
        if (&upd) begin
            upd      = '0;
            upd[way] = 1'b1;
        end
        return upd;
    endfunction

    // Tag compare on both ways of the addressed set
    always_comb begin
        hitWay = '0;
        hitIdx = '0;
        for (int w = 0; w < dcachePkg::NUM_WAYS; w++) begin
            hitWay[w] = validBits[setIdx][w] && (tagMem[setIdx][w] == reqTag);
            if (hitWay[w]) begin
                hitIdx = WAY_BITS'(w);
            end
        end
    end

    assign hit = |hitWay;

    // First way from 0 that is free or not recently used
    always_comb begin
        logic found;
        found     = 1'b0;
        victimIdx = '0;
        for (int w = 0; w < dcachePkg::NUM_WAYS; w++) begin
            if (!found && (!validBits[setIdx][w] || !statusBits[setIdx][w])) begin
                found     = 1'b1;
                victimIdx = WAY_BITS'(w);
            end
        end
    end

    assign victimTag   = tagMem[setIdx][victimIdx];
    assign victimDirty = validBits[setIdx][victimIdx] && dirtyBits[setIdx][victimIdx];

    // On a miss the victim block goes out so a write-back can use it
    assign readBlock = hit ? dataMem[setIdx][hitIdx] : dataMem[setIdx][victimIdx];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < dcachePkg::NUM_SETS; s++) begin
                validBits[s]  <= '0;
                statusBits[s] <= '0;
            end
        end else if (cmd.fill) begin
            validBits[setIdx][victimIdx] <= 1'b1;
            statusBits[setIdx]           <= touchStatus(statusBits[setIdx], victimIdx);
        end else if ((cmd.writeHit || cmd.lookup) && hit) begin
            statusBits[setIdx] <= touchStatus(statusBits[setIdx], hitIdx);
        end
    end

    // Tags, data and dirty bits
    always_ff @(posedge clk) begin
        if (cmd.fill) begin
            tagMem[setIdx][victimIdx]    <= reqTag;
            dataMem[setIdx][victimIdx]   <= cmd.data;
            dirtyBits[setIdx][victimIdx] <= 1'b0;    // fresh copy of memory
        end else if (cmd.writeHit && hit) begin
            for (int b = 0; b < dcachePkg::BLOCK_BYTES; b++) begin
                if (cmd.strobe[b]) begin
                    dataMem[setIdx][hitIdx][8*b +: 8] <= cmd.data[8*b +: 8];
                end
            end
            dirtyBits[setIdx][hitIdx] <= 1'b1;
        end
    end

endmodule

// File: hw/dcacheCtrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB completer FSM for the data cache: hit, write-back, refill
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module dcacheCtrl (
    input  logic                              clk,
    input  logic                              rst,
    input  dcachePkg::apbReq_t                apbReq,
    input  logic                              hit,
    input  logic                              victimDirty,
    input  logic [dcachePkg::TAG_BITS-1:0]    victimTag,
    input  logic [dcachePkg::BLOCK_BITS-1:0]  readBlock,
    input  dcachePkg::memResp_t               memResp,
    output dcachePkg::apbResp_t               apbResp,
    output dcachePkg::arrayCmd_t              cmd,
    output dcachePkg::memReq_t                memReq
);

    localparam int WORD_BITS = dcachePkg::WORD_BYTES * 8;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        FILL,
        DONE
    } ctrlState_t;

    ctrlState_t state;
    ctrlState_t nextState;

    dcachePkg::dcacheAddr_u           reqAddr;
    logic [dcachePkg::BLOCK_BITS-1:0] fillBlock;     // refill data held for the fill cycle
    logic [dcachePkg::BLOCK_BYTES-1:0] slotStrobe;
    logic [dcachePkg::BLOCK_BITS-1:0] slotData;
    logic                             complete;

    assign reqAddr = apbReq.paddr;

    // Word lanes moved into their slot of the block
    assign slotStrobe = dcachePkg::BLOCK_BYTES'(apbReq.pstrb)
                        << (reqAddr.field.wordSel * dcachePkg::WORD_BYTES);
    assign slotData   = dcachePkg::BLOCK_BITS'(apbReq.pwdata)
                        << (reqAddr.field.wordSel * WORD_BITS);

    always_comb begin
        nextState  = state;
        complete   = 1'b0;
        cmd        = '0;
        cmd.addr   = reqAddr;
        cmd.strobe = slotStrobe;
        cmd.data   = slotData;
        memReq     = '0;

        case (state)
            IDLE: begin
                if (apbReq.psel && !apbReq.penable) begin   // setup phase
                    nextState = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    complete  = 1'b1;   // zero wait states
                    nextState = IDLE;
                end else if (victimDirty) begin
                    nextState = WRITEBACK;
                end else begin
                    nextState = REFILL;
                end
            end
            WRITEBACK: begin
                // Victim block rebuilt from its tag and this set
                memReq.valid    = 1'b1;
                memReq.write    = 1'b1;
                memReq.blockNum = {victimTag, reqAddr.field.setIdx};
                memReq.data     = readBlock;
                if (memResp.done) begin
                    nextState = REFILL;
                end
            end
            REFILL: begin
                memReq.valid    = 1'b1;
                memReq.blockNum = reqAddr.block.blockNum;
                if (memResp.done) begin
                    nextState = FILL;
                end
            end
            FILL: begin
                cmd.fill  = 1'b1;
                cmd.data  = fillBlock;
                nextState = DONE;
            end
            DONE: begin
                complete  = 1'b1;   // block now present, finish as a hit
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase

        if (complete) begin
            cmd.lookup   = !apbReq.pwrite;
            cmd.writeHit = apbReq.pwrite;   // strobed merge on the same edge
        end
    end

    assign apbResp.pready = complete;
    assign apbResp.prdata = readBlock[reqAddr.field.wordSel * WORD_BITS +: WORD_BITS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == REFILL && memResp.done) begin
            fillBlock <= memResp.data;
        end
    end

endmodule

// File: hw/blockMemory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Backing memory model, block reads and writes after a fixed
// latency set by MEM_LATENCY
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module blockMemory #(
    parameter int MEM_LATENCY = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dcachePkg::memReq_t   memReq,
    output dcachePkg::memResp_t  memResp
);

    localparam int CNT_BITS  = $clog2(MEM_LATENCY + 1);
    localparam int WORDS     = dcachePkg::BLOCK_BYTES / dcachePkg::WORD_BYTES;
    localparam int WORD_BITS = dcachePkg::WORD_BYTES * 8;

    logic [dcachePkg::BLOCK_BITS-1:0] storage [dcachePkg::MEM_BLOCKS];
    logic [dcachePkg::BLOCK_BITS-1:0] readData;
    logic [CNT_BITS-1:0]              count;      // cycles since request seen
    logic [CNT_BITS-1:0]              countNext;
    logic                             busy;
    logic                             doneReg;
    logic                             start;
    logic                             fire;

    // Each word holds its own byte address plus a marker
    initial begin
        for (int b = 0; b < dcachePkg::MEM_BLOCKS; b++) begin
            for (int w = 0; w < WORDS; w++) begin
                storage[b][WORD_BITS*w +: WORD_BITS] =
                    32'(b * dcachePkg::BLOCK_BYTES + w * dcachePkg::WORD_BYTES) + 32'h1000_0000;
            end
        end
    end

    assign start     = memReq.valid && !busy && !doneReg;   // new request only after done drops
    assign countNext = start ? CNT_BITS'(1) : count + 1'b1;
    assign fire      = (start || busy) && (countNext == CNT_BITS'(MEM_LATENCY));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy    <= 1'b0;
            count   <= '0;
            doneReg <= 1'b0;
        end else begin
            doneReg <= fire;
            if (fire) begin
                busy <= 1'b0;
            end else if (start) begin
                busy <= 1'b1;
            end
            if (start || busy) begin
                count <= countNext;
            end
        end
    end

    // Transfer happens on the last latency cycle
    always_ff @(posedge clk) begin
        if (fire) begin
            if (memReq.write) begin
                storage[memReq.blockNum] <= memReq.data;
            end
            readData <= storage[memReq.blockNum];
        end
    end

    assign memResp = '{done: doneReg, data: readData};

endmodule

// File: hw/dcacheTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data cache top level, APB in, backing memory inside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module dcacheTop #(
    parameter int MEM_LATENCY = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dcachePkg::apbReq_t   apbReq,
    output dcachePkg::apbResp_t  apbResp
);

    dcachePkg::arrayCmd_t             cmd;
    logic                             hit;
    logic                             victimDirty;
    logic [dcachePkg::TAG_BITS-1:0]   victimTag;
    logic [dcachePkg::BLOCK_BITS-1:0] readBlock;
    dcachePkg::memReq_t               memReq;
    dcachePkg::memResp_t              memResp;

    dcacheCtrl ctrl (
        .clk         (clk),
        .rst         (rst),
        .apbReq      (apbReq),
        .hit         (hit),
        .victimDirty (victimDirty),
        .victimTag   (victimTag),
        .readBlock   (readBlock),
        .memResp     (memResp),
        .apbResp     (apbResp),
        .cmd         (cmd),
        .memReq      (memReq)
    );

    dcacheArray array (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .hit         (hit),
        .victimDirty (victimDirty),
        .victimTag   (victimTag),
        .readBlock   (readBlock)
    );

    blockMemory #(.MEM_LATENCY(MEM_LATENCY)) memory (
        .clk     (clk),
        .rst     (rst),
        .memReq  (memReq),
        .memResp (memResp)
    );

endmodule

// File: tb/dcacheRef.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference memory image for the cache testbench
// Included inside the testbench module and updated on each write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DCACHE_REF_SVH
`define DCACHE_REF_SVH

logic [7:0] refMem [1 << dcachePkg::ADDR_WIDTH];   // one byte per address

// Power-up word value is its own byte address plus a marker
function automatic logic [31:0] initialWord(input int addr);
    return 32'(addr & ~3) + 32'h1000_0000;
endfunction

function automatic void loadImage();
    logic [31:0] word;
    for (int a = 0; a < (1 << dcachePkg::ADDR_WIDTH); a++) begin
        word      = initialWord(a);
        refMem[a] = word[8*(a%4) +: 8];   // little-endian lanes
    end
endfunction

// Expected read word with the low two address bits ignored
function automatic logic [31:0] expectedWord(input logic [15:0] addr);
    logic [15:0] base;
    logic [31:0] word;
    base = {addr[15:2], 2'b00};
    for (int b = 0; b < 4; b++) begin
        word[8*b +: 8] = refMem[base + 16'(b)];
    end
    return word;
endfunction

function automatic void applyWrite(input logic [15:0] addr, input logic [31:0] data,
                                   input logic [3:0] strb);
    logic [15:0] base;
    base = {addr[15:2], 2'b00};
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            refMem[base + 16'(b)] = data[8*b +: 8];
        end
    end
endfunction

`endif

// File: tb/dcacheTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the data cache that checks APB accesses
// against a flat reference memory image
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module dcacheTb;

    localparam int MEM_LATENCY  = 4;
    localparam int NUM_ACCESSES = 319;   // all APB transfers below
    localparam int CYCLE_LIMIT  = NUM_ACCESSES * (2 * MEM_LATENCY + 8) + 100;

    logic                clk;
    logic                rst;
    dcachePkg::apbReq_t  apbReq;
    dcachePkg::apbResp_t apbResp;

    string       testName;
    int          errors;
    int          testStartErrors;
    int          passCount;
    int          failCount;
    int          cycles;

    `include "dcacheRef.svh"

    dcacheTop #(.MEM_LATENCY(MEM_LATENCY)) DUT (
        .clk     (clk),
        .rst     (rst),
        .apbReq  (apbReq),
        .apbResp (apbResp)
    );

    always #20 clk = ~clk;

    // Completed writes update the image and completed reads are compared
    always @(negedge clk) begin
        logic [31:0] expected;
        if (rst && apbReq.psel && apbReq.penable && apbResp.pready) begin
            if (apbReq.pwrite) begin
                applyWrite(apbReq.paddr, apbReq.pwdata, apbReq.pstrb);
            end else begin
                expected = expectedWord(apbReq.paddr);
                if (apbResp.prdata !== expected) begin
                    $display("Error %s: addr %h expected %h actual %h",
                             testName, apbReq.paddr, expected, apbResp.prdata);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // One APB transfer that counts access cycles with pready low
    task automatic apbAccess(input logic write, input logic [15:0] addr,
                             input logic [31:0] wdata, input logic [3:0] strb,
                             output int waitCount);
        logic finished;
        finished       = 1'b0;
        waitCount      = 0;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        apbReq.pstrb   = write ? strb : 4'b0;
        @(posedge clk);
        #1 apbReq.penable = 1'b1;
        while (!finished) begin
            @(negedge clk);
            if (apbResp.pready) begin
                finished = 1'b1;
            end else begin
                waitCount++;
            end
        end
        @(posedge clk);
        #1 apbReq.psel = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic readWord(input logic [15:0] addr, output int waitCount);
        apbAccess(1'b0, addr, 32'h0, 4'h0, waitCount);
    endtask

    task automatic writeWord(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        int waitCount;
        apbAccess(1'b1, addr, data, strb, waitCount);
    endtask

    task automatic checkWaits(input string what, input int waitCount, input bit expectHit);
        if (expectHit && waitCount != 0) begin
            $display("%s: %s took %0d wait states instead of none", testName, what, waitCount);
            errors++;
        end
        if (!expectHit && waitCount < MEM_LATENCY) begin
            $display("%s: %s took only %0d wait states but a miss needs at least %0d",
                     testName, what, waitCount, MEM_LATENCY);
            errors++;
        end
    endtask

    task automatic startTest(input string name);
        testName        = name;
        testStartErrors = errors;
    endtask

    task automatic finishTest();
        if (errors == testStartErrors) begin
            $display("%s: passed", testName);
            passCount++;
        end else begin
            $display("%s: failed with %0d errors", testName, errors - testStartErrors);
            failCount++;
        end
    endtask

    initial begin
        int          coldWaits;
        int          waits;
        int          tag;
        int          setSel;
        int          wordSel;
        logic [15:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        void'($urandom(32'h75bbdfa9));   // seed once for the whole run
        clk       = 1'b0;
        rst       = 1'b0;
        apbReq    = '0;
        errors    = 0;
        passCount = 0;
        failCount = 0;
        cycles    = 0;
        loadImage();

        startTest("reset_cold_read");
        repeat (8) begin
            @(posedge clk);
            #1;
            if (apbResp.pready !== 1'b0) begin
                $display("%s: pready was not low during reset", testName);
                errors++;
            end
        end
        rst = 1'b1;
        readWord(16'h1230, coldWaits);
        finishTest();

        startTest("hit_timing");
        readWord(16'h1234, waits);
        checkWaits("first read of the block", coldWaits, 1'b0);
        checkWaits("second read in the block", waits, 1'b1);
        finishTest();

        startTest("strobed_writes");
        writeWord(16'h0014, 32'hAABB_CCDD, 4'b0101);
        writeWord(16'h0014, 32'h1122_3344, 4'b1000);
        readWord(16'h0014, waits);
        writeWord(16'h0018, 32'hCAFE_F00D, 4'b0110);
        readWord(16'h0018, waits);
        finishTest();

        // Blocks A, B, C share set 4
        startTest("replacement");
        readWord(16'h0040, waits);
        readWord(16'h0240, waits);
        readWord(16'h0040, waits);
        readWord(16'h0440, waits);
        readWord(16'h0040, waits);
        checkWaits("read of block A", waits, 1'b1);
        readWord(16'h0240, waits);
        checkWaits("read of block B", waits, 1'b0);
        finishTest();

        // Dirty A and B in set 8 pushed out by C and D
        startTest("write_back");
        writeWord(16'h0080, 32'h0A0A_5A5A, 4'hF);
        writeWord(16'h0284, 32'h0B0B_6B6B, 4'hF);
        readWord(16'h0480, waits);
        readWord(16'h0680, waits);
        readWord(16'h0080, waits);
        readWord(16'h0284, waits);
        finishTest();

        startTest("random_mix");
        repeat (300) begin
            tag     = $urandom % 8;
            setSel  = 12 + $urandom % 2;   // two sets so evictions are frequent
            wordSel = $urandom % 4;
            addr    = 16'((tag << 9) | (setSel << 4) | (wordSel << 2));
            data    = $urandom;
            strb    = 4'(1 + $urandom % 15);
            if ($urandom % 2) begin
                writeWord(addr, data, strb);
            end else begin
                readWord(addr, waits);
            end
        end
        finishTest();

        $display("Tests passed: %0d  failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tb
hw/dcachePkg.sv
hw/dcacheArray.sv
hw/dcacheCtrl.sv
hw/blockMemory.sv
hw/dcacheTop.sv
tb/dcacheTb.sv

// File: run.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it and look for the pass line
verilator --binary -Wno-fatal -f vlog.f --top-module dcacheTb -o dcacheSim \
    && ./obj_dir/dcacheSim | tee /dev/stderr | grep -q "TEST OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
